// File: hw/etx.sv
module etx (
   input  logic                mi_clk,
   input  logic                rst_n,
   input  logic                mi_en,
   input  logic                mi_we,
   input  etx_pkg::mi_addr_t   mi_addr,
   input  etx_pkg::mi_data_t   mi_din,
   output etx_pkg::mi_data_t   mi_dout,
   input  logic                txwr_access,
   input  etx_pkg::packet_t    txwr_packet,
   output logic                txwr_wait,
   input  logic                txrd_access,
   input  etx_pkg::packet_t    txrd_packet,
   output logic                txrd_wait,
   input  logic                txrr_access,
   input  etx_pkg::packet_t    txrr_packet,
   output logic                txrr_wait,
   output logic                tx_frame,
   output etx_pkg::byte_t      tx_data,
   input  logic                txi_wr_wait,
   input  logic                txi_rd_wait
);

   etx_pkg::chan_in_t                         wr_in;      // Packed source inputs
   etx_pkg::chan_in_t                         rd_in;
   etx_pkg::chan_in_t                         rr_in;
   etx_pkg::chan_in_t [etx_pkg::NUM_CH-1:0]   chan_in;    // Ingress to queues
   etx_pkg::packet_t  [etx_pkg::NUM_CH-1:0]   head;       // Queue heads
   logic [etx_pkg::NUM_CH-1:0]                empty;
   logic [etx_pkg::NUM_CH-1:0]                pop;
   logic [etx_pkg::NUM_CH-1:0]                chan_wait;  // Almost-full per queue
   etx_pkg::drop_cnt_t                        drop_cnt;
   logic                                      tx_enable;
   etx_pkg::ctrlmode_t                        ctrlmode;
   logic                                      ctrlmode_bp;
   logic                                      issue;
   etx_pkg::packet_t                          issue_packet;
   logic                                      busy;

   assign wr_in = '{access: txwr_access, packet: txwr_packet};
   assign rd_in = '{access: txrd_access, packet: txrd_packet};
   assign rr_in = '{access: txrr_access, packet: txrr_packet};

   etx_ingress u_ingress (
      .mi_clk   (mi_clk),
      .rst_n    (rst_n),
      .wr_in    (wr_in),
      .rd_in    (rd_in),
      .rr_in    (rr_in),
      .chan_out (chan_in),
      .drop_cnt (drop_cnt)
   );

   for (genvar i = 0; i < etx_pkg::NUM_CH; i++)
   begin : g_chan
      etx_chan_fifo u_fifo (
         .mi_clk     (mi_clk),
         .rst_n      (rst_n),
         .wr         (chan_in[i]),
         .pop        (pop[i]),
         .head       (head[i]),
         .empty      (empty[i]),
         .wait_level (chan_wait[i])
      );
   end

   assign txwr_wait = chan_wait[etx_pkg::CH_WR];
   assign txrd_wait = chan_wait[etx_pkg::CH_RD];
   assign txrr_wait = chan_wait[etx_pkg::CH_RR];

   etx_arbiter u_arbiter (
      .mi_clk       (mi_clk),
      .rst_n        (rst_n),
      .tx_enable    (tx_enable),
      .ctrlmode     (ctrlmode),
      .ctrlmode_bp  (ctrlmode_bp),
      .txi_wr_wait  (txi_wr_wait),
      .txi_rd_wait  (txi_rd_wait),
      .empty        (empty),
      .head         (head),
      .busy         (busy),
      .pop          (pop),
      .issue        (issue),
      .issue_packet (issue_packet)
   );

   etx_framer u_framer (
      .mi_clk       (mi_clk),
      .rst_n        (rst_n),
      .issue        (issue),
      .issue_packet (issue_packet),
      .busy         (busy),
      .tx_frame     (tx_frame),
      .tx_data      (tx_data)
   );

   etx_cfg u_cfg (
      .mi_clk      (mi_clk),
      .rst_n       (rst_n),
      .mi_en       (mi_en),
      .mi_we       (mi_we),
      .mi_addr     (mi_addr),
      .mi_din      (mi_din),
      .mi_dout     (mi_dout),
      .tx_enable   (tx_enable),
      .ctrlmode    (ctrlmode),
      .ctrlmode_bp (ctrlmode_bp),
      .chan_wait   (chan_wait),
      .drop_cnt    (drop_cnt)
   );

endmodule

// File: hw/etx_arbiter.sv
module etx_arbiter (
   input  logic                                      mi_clk,
   input  logic                                      rst_n,
   input  logic                                      tx_enable,
   input  etx_pkg::ctrlmode_t                        ctrlmode,
   input  logic                                      ctrlmode_bp,
   input  logic                                      txi_wr_wait,
   input  logic                                      txi_rd_wait,
   input  logic [etx_pkg::NUM_CH-1:0]                empty,
   input  etx_pkg::packet_t [etx_pkg::NUM_CH-1:0]    head,
   input  logic                                      busy,
   output logic [etx_pkg::NUM_CH-1:0]                pop,
   output logic                                      issue,
   output etx_pkg::packet_t                          issue_packet
);

   logic [etx_pkg::NUM_CH-1:0] blocked;       // Link wait per channel
   logic [etx_pkg::NUM_CH-1:0] elig;          // Non-empty and not blocked
   logic [etx_pkg::NUM_CH-1:0] grant;         // One-hot winner
   etx_pkg::packet_t           pick;          // Winner's head
   logic                       take;          // Pop this cycle
   logic                       staged_valid;  // Packet waiting to issue

   // Read requests stall on rd wait, the rest on wr wait
   assign blocked[etx_pkg::CH_WR] = txi_wr_wait;
   assign blocked[etx_pkg::CH_RD] = txi_rd_wait;
   assign blocked[etx_pkg::CH_RR] = txi_wr_wait;
   assign elig = ~empty & ~blocked;

   // Higher index wins
   always_comb
   begin
      grant = '0;
      pick  = head[etx_pkg::CH_WR];
      for (int i = 0; i < etx_pkg::NUM_CH; i++)
      begin
         if (elig[i])
         begin
            grant    = '0;
            grant[i] = 1'b1;
            pick     = head[i];
         end
      end
   end

   assign take  = tx_enable & ~busy & ~staged_valid & (|elig);
   assign pop   = take ? grant : '0;
   assign issue = staged_valid & ~busy;

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         staged_valid <= 1'b0;
      end
      else if (take)
      begin
         staged_valid <= 1'b1;
      end
      else if (issue)
      begin
         staged_valid <= 1'b0;  // Handed to framer
      end
   end

   // Staged packet with optional ctrlmode override
   always_ff @(posedge mi_clk)
   begin
      if (take)
      begin
         issue_packet <= pick;
         if (ctrlmode_bp)
         begin
            issue_packet.ctrlmode <= ctrlmode;
         end
      end
   end

endmodule

// File: hw/etx_cfg.sv
module etx_cfg (
   input  logic                                mi_clk,
   input  logic                                rst_n,
   input  logic                                mi_en,
   input  logic                                mi_we,
   input  etx_pkg::mi_addr_t                   mi_addr,
   input  etx_pkg::mi_data_t                   mi_din,
   output etx_pkg::mi_data_t                   mi_dout,
   output logic                                tx_enable,
   output etx_pkg::ctrlmode_t                  ctrlmode,
   output logic                                ctrlmode_bp,
   input  logic [etx_pkg::NUM_CH-1:0]          chan_wait,
   input  etx_pkg::drop_cnt_t                  drop_cnt
);

   logic [etx_pkg::CFG_BP_BIT:0] cfg_q;     // Writable config bits 5:0
   etx_pkg::mi_data_t            status_q;  // Sampled status word
   logic                         cfg_wr;    // Config write this cycle
   logic                         rd;        // Read access this cycle

   assign cfg_wr = mi_en & mi_we & (mi_addr == etx_pkg::REG_TX_CFG);
   assign rd     = mi_en & ~mi_we;

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         cfg_q <= '0;  // TX off after reset
      end
      else if (cfg_wr)
      begin
         cfg_q <= mi_din[etx_pkg::CFG_BP_BIT:0];  // Upper bits not kept
      end
   end

   // Status sampled every cycle
   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         status_q <= '0;
      end
      else
      begin
         status_q <= {16'b0, drop_cnt, 5'b0, chan_wait};  // 15:8 drops, 2:0 waits
      end
   end

   // Registered read-back mux
   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         mi_dout <= '0;
      end
      else if (rd)
      begin
         case (mi_addr)
            etx_pkg::REG_TX_CFG:    mi_dout <= etx_pkg::mi_data_t'(cfg_q);
            etx_pkg::REG_TX_STATUS: mi_dout <= status_q;
            default:                mi_dout <= '0;  // Unmapped reads zero
         endcase
      end
   end

   assign tx_enable   = cfg_q[etx_pkg::CFG_ENABLE_BIT];
   assign ctrlmode    = cfg_q[etx_pkg::CFG_CTRLMODE_LSB +: 4];
   assign ctrlmode_bp = cfg_q[etx_pkg::CFG_BP_BIT];

endmodule

// File: hw/etx_chan_fifo.sv
module etx_chan_fifo (
   input  logic               mi_clk,
   input  logic               rst_n,
   input  etx_pkg::chan_in_t  wr,
   input  logic               pop,
   output etx_pkg::packet_t   head,
   output logic               empty,
   output logic               wait_level
);

   localparam int PTR_W = $clog2(etx_pkg::FIFO_DEPTH);

   etx_pkg::packet_t   mem [etx_pkg::FIFO_DEPTH];  // Packet storage
   logic [PTR_W-1:0]   wr_ptr;                     // Next free slot
   logic [PTR_W-1:0]   rd_ptr;                     // Head slot
   etx_pkg::fifo_cnt_t count;                      // Occupancy
   logic               full;
   logic               wr_en;                      // Accepted write
   logic               rd_en;                      // Accepted pop

   assign full  = count == etx_pkg::fifo_cnt_t'(etx_pkg::FIFO_DEPTH);
   assign empty = count == '0;
   assign wr_en = wr.access & ~full;  // Write to a full queue is ignored
   assign rd_en = pop & ~empty;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(etx_pkg::FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   always_ff @(posedge mi_clk)
   begin
      if (wr_en)
      begin
         mem[wr_ptr] <= wr.packet;
      end
   end

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (rd_en)
         begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

   assign head       = mem[rd_ptr];  // Show-ahead head
   assign wait_level = count >= etx_pkg::fifo_cnt_t'(etx_pkg::WAIT_LEVEL);

endmodule

// File: hw/etx_framer.sv
module etx_framer (
   input  logic              mi_clk,
   input  logic              rst_n,
   input  logic              issue,
   input  etx_pkg::packet_t  issue_packet,
   output logic              busy,
   output logic              tx_frame,
   output etx_pkg::byte_t    tx_data
);

   localparam int SHIFT_W = etx_pkg::FRAME_BYTES * 8;
   localparam int IDX_W   = $clog2(etx_pkg::FRAME_BYTES);

   etx_pkg::framer_state_t state;
   logic [IDX_W-1:0]       idx;      // Byte on the link now
   logic [SHIFT_W-1:0]     shift_q;  // Remaining bytes, MSB first
   logic                   last;     // Final byte on the link

   assign last = idx == IDX_W'(etx_pkg::FRAME_BYTES - 1);

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         state    <= etx_pkg::FR_IDLE;
         tx_frame <= 1'b0;
         idx      <= '0;
      end
      else
      begin
         case (state)
            etx_pkg::FR_IDLE:
            begin
               if (issue)
               begin
                  state    <= etx_pkg::FR_SEND;
                  tx_frame <= 1'b1;  // Header byte goes out now
                  idx      <= '0;
               end
            end
            etx_pkg::FR_SEND:
            begin
               if (last)
               begin
                  state    <= etx_pkg::FR_IDLE;
                  tx_frame <= 1'b0;  // Gap before next transfer
               end
               else
               begin
                  idx <= idx + 1'b1;
               end
            end
            default:
            begin
               state    <= etx_pkg::FR_IDLE;
               tx_frame <= 1'b0;
            end
         endcase
      end
   end

   // Header byte is {0, write, datamode, ctrlmode}
   always_ff @(posedge mi_clk)
   begin
      if (issue && state == etx_pkg::FR_IDLE)
      begin
         shift_q <= {1'b0, issue_packet};
      end
      else if (state == etx_pkg::FR_SEND)
      begin
         shift_q <= shift_q << 8;  // Next byte to the top
      end
   end

   assign tx_data = shift_q[SHIFT_W-1 -: 8];
   assign busy    = state == etx_pkg::FR_SEND;

endmodule

// File: hw/etx_ingress.sv
module etx_ingress (
   input  logic                                        mi_clk,
   input  logic                                        rst_n,
   input  etx_pkg::chan_in_t                           wr_in,
   input  etx_pkg::chan_in_t                           rd_in,
   input  etx_pkg::chan_in_t                           rr_in,
   output etx_pkg::chan_in_t [etx_pkg::NUM_CH-1:0]     chan_out,
   output etx_pkg::drop_cnt_t                          drop_cnt
);

   logic wr_drop;  // Write request to this chip
   logic rd_drop;  // Read request to this chip

   function automatic logic is_local(input etx_pkg::packet_t pkt);
      return pkt.dst_addr[31:20] == etx_pkg::CHIP_ID;  // Top 12 bits are the chip
   endfunction

   assign wr_drop = wr_in.access & is_local(wr_in.packet);
   assign rd_drop = rd_in.access & is_local(rd_in.packet);

   // Write strobes, filtered
   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         chan_out[etx_pkg::CH_WR].access <= 1'b0;
         chan_out[etx_pkg::CH_RD].access <= 1'b0;
         chan_out[etx_pkg::CH_RR].access <= 1'b0;
      end
      else
      begin
         chan_out[etx_pkg::CH_WR].access <= wr_in.access & ~wr_drop;
         chan_out[etx_pkg::CH_RD].access <= rd_in.access & ~rd_drop;
         chan_out[etx_pkg::CH_RR].access <= rr_in.access;  // Responses pass unfiltered
      end
   end

   // Payload stage
   always_ff @(posedge mi_clk)
   begin
      chan_out[etx_pkg::CH_WR].packet <= wr_in.packet;
      chan_out[etx_pkg::CH_RD].packet <= rd_in.packet;
      chan_out[etx_pkg::CH_RR].packet <= rr_in.packet;
   end

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         drop_cnt <= '0;
      end
      else
      begin
         // Both may drop in one cycle
         drop_cnt <= drop_cnt + etx_pkg::drop_cnt_t'(wr_drop)
                              + etx_pkg::drop_cnt_t'(rd_drop);
      end
   end

endmodule

// File: hw/etx_pkg.sv
package etx_pkg;

   typedef logic [19:0] mi_addr_t;   // Register bus address
   typedef logic [31:0] mi_data_t;   // Register bus data
   typedef logic [31:0] addr_t;      // Mesh address
   typedef logic [31:0] word_t;      // Mesh data word
   typedef logic [3:0]  ctrlmode_t;  // Packet control mode
   typedef logic [11:0] chip_id_t;   // Chip coordinate, top address bits
   typedef logic [7:0]  byte_t;      // One link byte
   typedef logic [3:0]  fifo_cnt_t;  // Queue occupancy 0..8
   typedef logic [7:0]  drop_cnt_t;  // Dropped packets, wraps

   // Mesh packet, MSB first as it goes on the link
   typedef struct packed {
      logic       write;     // Write vs read
      logic [1:0] datamode;  // Transfer size
      ctrlmode_t  ctrlmode;  // Control mode
      addr_t      dst_addr;  // Destination
      word_t      data;      // Payload
      addr_t      src_addr;  // Source / return address
   } packet_t;

   typedef struct packed {
      logic    access;  // Write strobe
      packet_t packet;  // Entry payload
   } chan_in_t;

   typedef enum logic {
      FR_IDLE,  // Waiting for issue
      FR_SEND   // Bytes on the link
   } framer_state_t;

   localparam int NUM_CH = 3;  // Queue count
   localparam int CH_WR  = 0;  // Write requests, lowest priority
   localparam int CH_RD  = 1;  // Read requests
   localparam int CH_RR  = 2;  // Read responses, highest priority

   localparam chip_id_t CHIP_ID = 12'h808;  // Packets to this chip are dropped

   localparam int FIFO_DEPTH  = 8;   // Entries per queue
   localparam int WAIT_LEVEL  = 6;   // Almost-full threshold
   localparam int FRAME_BYTES = 13;  // Bytes per transfer

   localparam mi_addr_t REG_TX_CFG    = 20'hF0200;  // Enable and ctrlmode
   localparam mi_addr_t REG_TX_STATUS = 20'hF0204;  // Waits and drop count

   localparam int CFG_ENABLE_BIT   = 0;  // TX enable
   localparam int CFG_CTRLMODE_LSB = 1;  // 4-bit ctrlmode field
   localparam int CFG_BP_BIT       = 5;  // Ctrlmode override

endpackage

// File: run.sh
#!/usr/bin/env bash
# Build the etx testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module etx_tb -o etx_sim &&
./obj_dir/etx_sim || { echo "simulation did not pass"; exit 1; }

// File: sources.f
hw/etx_pkg.sv
hw/etx_cfg.sv
hw/etx_ingress.sv
hw/etx_chan_fifo.sv
hw/etx_arbiter.sv
hw/etx_framer.sv
hw/etx.sv
tb/etx_tb.sv

// File: tb/etx_tb.sv
module etx_tb;

   localparam int N_RAND      = 60;  // Random packets per traffic phase
   localparam int N_PKTS      = 3 * etx_pkg::WAIT_LEVEL + 12 + 2 * N_RAND + 17;
   localparam int STIM_CYCLES = N_PKTS * 16 + 200;  // Send plus frame time per packet
   localparam int FRAME_W     = etx_pkg::FRAME_BYTES * 8;
   localparam etx_pkg::mi_data_t  CFG_ON  = 32'd1 << etx_pkg::CFG_ENABLE_BIT;
   localparam etx_pkg::ctrlmode_t BP_MODE = 4'hA;  // Override value

   logic                mi_clk = 1'b0;
   logic                rst_n;
   logic                mi_en;
   logic                mi_we;
   etx_pkg::mi_addr_t   mi_addr;
   etx_pkg::mi_data_t   mi_din;
   etx_pkg::mi_data_t   mi_dout;
   logic                txwr_access;
   logic                txrd_access;
   logic                txrr_access;
   etx_pkg::packet_t    txwr_packet;
   etx_pkg::packet_t    txrd_packet;
   etx_pkg::packet_t    txrr_packet;
   logic                txwr_wait;
   logic                txrd_wait;
   logic                txrr_wait;
   logic                tx_frame;
   etx_pkg::byte_t      tx_data;
   logic                txi_wr_wait;
   logic                txi_rd_wait;

   logic [31:0]         lfsr = 32'h5db4_9f15;           // Stimulus LFSR state
   etx_pkg::packet_t    exp_q [etx_pkg::NUM_CH][$];     // Expected packets per channel
   int                  order_log [$];                  // Channel of each frame seen
   int                  drops = 0;                      // Packets sent to this chip
   logic                bp_on = 1'b0;                   // Ctrlmode override active
   logic [FRAME_W-1:0]  frame_buf;                      // Bytes of current frame
   int                  nbytes = 0;
   logic                start_wr_wait;                  // Link waits at frame start
   logic                start_rd_wait;

   always #4 mi_clk = ~mi_clk;

   etx UUT (
      .mi_clk      (mi_clk),
      .rst_n       (rst_n),
      .mi_en       (mi_en),
      .mi_we       (mi_we),
      .mi_addr     (mi_addr),
      .mi_din      (mi_din),
      .mi_dout     (mi_dout),
      .txwr_access (txwr_access),
      .txwr_packet (txwr_packet),
      .txwr_wait   (txwr_wait),
      .txrd_access (txrd_access),
      .txrd_packet (txrd_packet),
      .txrd_wait   (txrd_wait),
      .txrr_access (txrr_access),
      .txrr_packet (txrr_packet),
      .txrr_wait   (txrr_wait),
      .tx_frame    (tx_frame),
      .tx_data     (tx_data),
      .txi_wr_wait (txi_wr_wait),
      .txi_rd_wait (txi_rd_wait)
   );

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp)
      else
         report_failure($sformatf("Fail %s expected %h actual %h", name, exp, act));
   endtask

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Channel tag rides in src_addr[1:0]
   function automatic etx_pkg::packet_t make_packet(input int ch, input logic allow_local);
      etx_pkg::packet_t pkt;
      pkt.write    = 1'(rand_bits(1));
      pkt.datamode = 2'(rand_bits(2));
      pkt.ctrlmode = 4'(rand_bits(4));
      pkt.dst_addr = rand_bits(32);
      pkt.data     = rand_bits(32);
      pkt.src_addr = {30'(rand_bits(30)), 2'(ch)};
      if (allow_local && rand_bits(2) == 32'd0)
         pkt.dst_addr[31:20] = etx_pkg::CHIP_ID;  // About one in four goes local
      else if (pkt.dst_addr[31:20] == etx_pkg::CHIP_ID)
         pkt.dst_addr[31] = ~pkt.dst_addr[31];
      return pkt;
   endfunction

   function automatic logic wait_of(input int ch);
      case (ch)
         etx_pkg::CH_WR: return txwr_wait;
         etx_pkg::CH_RD: return txrd_wait;
         default:        return txrr_wait;
      endcase
   endfunction

   function automatic int pending();
      return exp_q[0].size() + exp_q[1].size() + exp_q[2].size();
   endfunction

   task automatic write_reg(input etx_pkg::mi_addr_t addr, input etx_pkg::mi_data_t data);
      @(posedge mi_clk);
      mi_en   <= 1'b1;
      mi_we   <= 1'b1;
      mi_addr <= addr;
      mi_din  <= data;
      @(posedge mi_clk);
      mi_en   <= 1'b0;
      mi_we   <= 1'b0;
   endtask

   task automatic read_reg(input etx_pkg::mi_addr_t addr, output etx_pkg::mi_data_t data);
      @(posedge mi_clk);
      mi_en   <= 1'b1;
      mi_we   <= 1'b0;
      mi_addr <= addr;
      @(posedge mi_clk);
      mi_en   <= 1'b0;
      @(negedge mi_clk);
      data = mi_dout;  // Registered read-back now valid
   endtask

   // One strobe then an idle cycle so the wait level is current
   task automatic send_packet(input int ch, input etx_pkg::packet_t pkt);
      @(negedge mi_clk);
      while (wait_of(ch))
         @(negedge mi_clk);
      @(posedge mi_clk);
      case (ch)
         etx_pkg::CH_WR:
         begin
            txwr_access <= 1'b1;
            txwr_packet <= pkt;
         end
         etx_pkg::CH_RD:
         begin
            txrd_access <= 1'b1;
            txrd_packet <= pkt;
         end
         default:
         begin
            txrr_access <= 1'b1;
            txrr_packet <= pkt;
         end
      endcase
      @(posedge mi_clk);
      txwr_access <= 1'b0;
      txrd_access <= 1'b0;
      txrr_access <= 1'b0;
      @(posedge mi_clk);
      if (ch != etx_pkg::CH_RR && pkt.dst_addr[31:20] == etx_pkg::CHIP_ID)
         drops++;  // Mirror of the ingress filter
      else
         exp_q[ch].push_back(pkt);
   endtask

   task automatic wait_drain();
      while (pending() != 0)
         @(negedge mi_clk);
      repeat (4) @(negedge mi_clk);
   endtask

   task automatic check_frame();
      etx_pkg::packet_t got;
      etx_pkg::packet_t exp;
      int               ch;
      assert (nbytes == etx_pkg::FRAME_BYTES)
      else
         report_failure($sformatf("A frame carried %0d bytes instead of 13", nbytes));
      check_value("tx_data header bit 7", 32'd0, 32'(frame_buf[FRAME_W-1]));
      got = frame_buf[FRAME_W-2:0];
      ch  = int'(got.src_addr[1:0]);
      assert (ch < etx_pkg::NUM_CH)
      else
         report_failure("A frame carried an unknown channel tag");
      assert (exp_q[ch].size() > 0)
      else
         report_failure("A frame came out that no source had queued");
      exp = exp_q[ch].pop_front();
      if (bp_on)
         exp.ctrlmode = BP_MODE;
      assert (got === exp)
      else
         report_failure($sformatf("Fail tx_data packet expected %h actual %h", exp, got));
      assert (!(ch == etx_pkg::CH_RD && start_rd_wait))
      else
         report_failure("A read request frame started while txi_rd_wait was high");
      assert (!(ch != etx_pkg::CH_RD && start_wr_wait))
      else
         report_failure("A write or response frame started while txi_wr_wait was high");
      order_log.push_back(ch);
   endtask

   // Link monitor sampling between edges
   always @(negedge mi_clk)
   begin
      if (rst_n)
      begin
         if (tx_frame)
         begin
            if (nbytes == 0)
            begin
               start_wr_wait = txi_wr_wait;
               start_rd_wait = txi_rd_wait;
            end
            frame_buf = {frame_buf[FRAME_W-9:0], tx_data};
            nbytes++;
         end
         else if (nbytes != 0)
         begin
            check_frame();  // Frame just ended
            nbytes = 0;
         end
      end
   end

   initial
   begin
      repeat (STIM_CYCLES * 20) @(posedge mi_clk);
      report_failure("Watchdog expired before the tests finished");
   end

   initial
   begin
      int                ch;
      etx_pkg::mi_data_t rd;
      rst_n       <= 1'b0;
      mi_en       <= 1'b0;
      mi_we       <= 1'b0;
      mi_addr     <= '0;
      mi_din      <= '0;
      txwr_access <= 1'b0;
      txrd_access <= 1'b0;
      txrr_access <= 1'b0;
      txwr_packet <= '0;
      txrd_packet <= '0;
      txrr_packet <= '0;
      txi_wr_wait <= 1'b0;
      txi_rd_wait <= 1'b0;
      repeat (8) @(posedge mi_clk);
      rst_n <= 1'b1;

      // Reset state and register access
      @(negedge mi_clk);
      check_value("tx_frame", 32'd0, 32'(tx_frame));
      check_value("mi_dout", 32'd0, mi_dout);
      check_value("txwr_wait", 32'd0, 32'(txwr_wait));
      check_value("txrd_wait", 32'd0, 32'(txrd_wait));
      check_value("txrr_wait", 32'd0, 32'(txrr_wait));
      read_reg(etx_pkg::REG_TX_CFG, rd);
      check_value("REG_TX_CFG", 32'd0, rd);
      write_reg(etx_pkg::REG_TX_CFG, 32'hFFFF_FFDE);  // TX stays off
      read_reg(etx_pkg::REG_TX_CFG, rd);
      check_value("REG_TX_CFG", 32'h0000_001E, rd);
      read_reg(20'hF0208, rd);
      check_value("unmapped mi_dout", 32'd0, rd);
      write_reg(etx_pkg::REG_TX_CFG, 32'd0);

      // Wait level with TX off
      for (int c = 0; c < etx_pkg::NUM_CH; c++)
         for (int i = 0; i < etx_pkg::WAIT_LEVEL; i++)
            send_packet(c, make_packet(c, 1'b0));
      repeat (2) @(negedge mi_clk);
      check_value("txwr_wait", 32'd1, 32'(txwr_wait));
      check_value("txrd_wait", 32'd1, 32'(txrd_wait));
      check_value("txrr_wait", 32'd1, 32'(txrr_wait));
      read_reg(etx_pkg::REG_TX_STATUS, rd);
      check_value("REG_TX_STATUS waits", 32'h7, 32'(rd[2:0]));
      write_reg(etx_pkg::REG_TX_CFG, CFG_ON);
      wait_drain();
      check_value("txwr_wait", 32'd0, 32'(txwr_wait));
      check_value("txrd_wait", 32'd0, 32'(txrd_wait));
      check_value("txrr_wait", 32'd0, 32'(txrr_wait));
      read_reg(etx_pkg::REG_TX_STATUS, rd);
      check_value("REG_TX_STATUS waits", 32'h0, 32'(rd[2:0]));

      // Priority with queues filled below the wait level
      write_reg(etx_pkg::REG_TX_CFG, 32'd0);
      for (int i = 0; i < etx_pkg::WAIT_LEVEL - 2; i++)
         for (int c = 0; c < etx_pkg::NUM_CH; c++)
            send_packet(c, make_packet(c, 1'b0));
      order_log.delete();
      write_reg(etx_pkg::REG_TX_CFG, CFG_ON);
      wait_drain();
      for (int i = 1; i < order_log.size(); i++)
         assert (order_log[i] <= order_log[i-1])
         else
            report_failure("A lower priority frame went out before a higher one");

      // Random traffic plain then with ctrlmode override
      for (int i = 0; i < N_RAND; i++)
      begin
         ch = int'(rand_bits(2) % 32'd3);
         send_packet(ch, make_packet(ch, 1'b1));
      end
      wait_drain();
      bp_on = 1'b1;
      write_reg(etx_pkg::REG_TX_CFG, (32'd1 << etx_pkg::CFG_BP_BIT) | CFG_ON
                | (32'(BP_MODE) << etx_pkg::CFG_CTRLMODE_LSB));
      for (int i = 0; i < N_RAND; i++)
      begin
         ch = int'(rand_bits(2) % 32'd3);
         send_packet(ch, make_packet(ch, 1'b1));
      end
      wait_drain();
      write_reg(etx_pkg::REG_TX_CFG, CFG_ON);
      bp_on = 1'b0;

      // Read wait holds reads while writes still flow
      @(posedge mi_clk);
      txi_rd_wait <= 1'b1;
      for (int i = 0; i < 4; i++)
      begin
         send_packet(etx_pkg::CH_RD, make_packet(etx_pkg::CH_RD, 1'b0));
         send_packet(etx_pkg::CH_WR, make_packet(etx_pkg::CH_WR, 1'b0));
      end
      while (exp_q[etx_pkg::CH_WR].size() != 0)
         @(negedge mi_clk);
      repeat (16) @(negedge mi_clk);
      check_value("held read requests", 32'd4, 32'(exp_q[etx_pkg::CH_RD].size()));
      @(posedge mi_clk);
      txi_rd_wait <= 1'b0;
      wait_drain();

      // Write wait holds writes and responses
      @(posedge mi_clk);
      txi_wr_wait <= 1'b1;
      for (int i = 0; i < 3; i++)
         for (int c = 0; c < etx_pkg::NUM_CH; c++)
            send_packet(c, make_packet(c, 1'b0));
      while (exp_q[etx_pkg::CH_RD].size() != 0)
         @(negedge mi_clk);
      repeat (16) @(negedge mi_clk);
      check_value("held write requests", 32'd3, 32'(exp_q[etx_pkg::CH_WR].size()));
      check_value("held read responses", 32'd3, 32'(exp_q[etx_pkg::CH_RR].size()));
      @(posedge mi_clk);
      txi_wr_wait <= 1'b0;
      wait_drain();

      // Drop count wraps at 256
      read_reg(etx_pkg::REG_TX_STATUS, rd);
      check_value("REG_TX_STATUS drop_cnt", 32'(drops & 255), 32'(rd[15:8]));

      $display("Everything OK");
      $finish;
   end

endmodule
